//--- src/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`default_nettype none

// datapath widths
`define XLEN    32
`define REG_AW  5

// clint register map, full 32-bit word addresses
`define MTIMECMP_LO 32'h0200_4000
`define MTIMECMP_HI 32'h0200_4004
`define MTIME_LO    32'h0200_BFF8
`define MTIME_HI    32'h0200_BFFC

// data ram geometry
`define DMEM_WORDS   1024
`define DMEM_LATENCY 2  // cycles from req seen to ack

`default_nettype wire

`endif

//--- src/rv_isa_pkg.sv
`include "core_params.svh"
`default_nettype none

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] word_t;

  // load/store opcode as it arrives from execute
  typedef enum logic [3:0] {
    MEMOP_NONE = 4'd0,
    MEMOP_LB   = 4'd1,
    MEMOP_LBU  = 4'd2,
    MEMOP_LH   = 4'd3,
    MEMOP_LHU  = 4'd4,
    MEMOP_LW   = 4'd5,
    MEMOP_SB   = 4'd6,
    MEMOP_SH   = 4'd7,
    MEMOP_SW   = 4'd8
  } memop_e;

  // access size code, also carried on the dmem bus
  typedef logic [1:0] size_t;
  localparam size_t SZ_B = 2'd0;
  localparam size_t SZ_H = 2'd1;
  localparam size_t SZ_W = 2'd2;

  // exception bits raised by the memory stage
  typedef struct packed {
    logic load_misalign;
    logic store_misalign;
  } trap_t;

endpackage

`default_nettype wire

//--- src/pipe_pkg.sv
`include "core_params.svh"
`default_nettype none

package pipe_pkg;

  // ex/mem payload
  typedef struct packed {
    rv_isa_pkg::word_t  pc;
    logic [`REG_AW-1:0] rd;
    rv_isa_pkg::memop_e op;
    rv_isa_pkg::word_t  alu;  // effective address or alu result
    rv_isa_pkg::word_t  rs2;  // store source
  } ex_mem_t;

  // mem/wb payload
  typedef struct packed {
    rv_isa_pkg::word_t  pc;
    logic [`REG_AW-1:0] rd;
    rv_isa_pkg::word_t  data;
    rv_isa_pkg::trap_t  trap;
  } mem_wb_t;

endpackage

`default_nettype wire

//--- src/mem_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// four-phase req/ack link between the memory stage and the data ram
interface dmem_if;
  import rv_isa_pkg::*;

  logic   req;
  logic   we;
  word_t  addr;
  logic [3:0] mask;  // byte enables, already shifted to the lane
  size_t  size;
  word_t  wdata;
  logic   ack;
  word_t  rdata;

  modport stage (output req, we, addr, mask, size, wdata, input ack, rdata);
  modport ram   (input req, we, addr, mask, size, wdata, output ack, rdata);
endinterface

// single-cycle clint access, no handshake
interface clint_if;
  import rv_isa_pkg::*;

  logic  sel;
  logic  we;
  word_t addr;
  word_t wdata;
  word_t rdata;  // combinational read

  modport stage (output sel, we, addr, wdata, input rdata);
  modport clint (input sel, we, addr, wdata, output rdata);
endinterface

`default_nettype wire

//--- src/lsu_ext.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_ext (
  input  rv_isa_pkg::word_t data_i,
  input  logic [1:0]        offset_i,  // byte lane of the access
  input  rv_isa_pkg::size_t size_i,
  input  logic              signed_i,
  output rv_isa_pkg::word_t data_o
);
  import rv_isa_pkg::*;

  localparam int W = $bits(word_t);

  word_t lane;
  logic  sign_b;
  logic  sign_h;

  // move the addressed byte down to bit 0
  assign lane = data_i >> {offset_i, 3'b000};

  assign sign_b = signed_i & lane[7];
  assign sign_h = signed_i & lane[15];

  always_comb begin
    case (size_i)
      SZ_B:    data_o = {{(W - 8){sign_b}}, lane[7:0]};
      SZ_H:    data_o = {{(W - 16){sign_h}}, lane[15:0]};
      default: data_o = lane;  // full word, nothing to extend
    endcase
  end

endmodule

`default_nettype wire

//--- src/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     hold_i,   // keep current contents
  input  logic     flush_i,  // load a bubble instead
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (!hold_i) begin
      valid_q <= valid_i & ~flush_i;
    end
  end

  // payload only matters while valid
  always_ff @(posedge clk) begin
    if (!hold_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

`default_nettype wire

//--- src/mem_stage.sv
`include "core_params.svh"
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
  input  logic              clk,
  input  logic              rst_n_i,
  input  pipe_pkg::ex_mem_t ex_i,
  input  logic              ex_valid_i,
  dmem_if.stage             dmem,
  clint_if.stage            clint,
  output logic              stall_o,
  output pipe_pkg::mem_wb_t wb_o
);
  import rv_isa_pkg::*;
  import pipe_pkg::*;

  logic       is_load;
  logic       is_store;
  logic       is_mem;
  logic       ld_signed;
  size_t      size;
  logic [1:0] off;
  logic       misalign;
  logic       is_clint;
  logic       acc_ok;
  logic       ram_acc;
  logic       clint_acc;
  logic [3:0] base_mask;
  word_t      st_trim;
  word_t      st_wdata;
  word_t      ld_raw;
  word_t      ld_data;
  trap_t      trap;
  logic       wait_ack_q;  // previous ack still has to drop

  // op decode
  assign is_load   = ex_i.op inside {MEMOP_LB, MEMOP_LBU, MEMOP_LH, MEMOP_LHU, MEMOP_LW};
  assign is_store  = ex_i.op inside {MEMOP_SB, MEMOP_SH, MEMOP_SW};
  assign is_mem    = is_load | is_store;
  assign ld_signed = ex_i.op inside {MEMOP_LB, MEMOP_LH, MEMOP_LW};

  always_comb begin
    case (ex_i.op)
      MEMOP_LB, MEMOP_LBU, MEMOP_SB: size = SZ_B;
      MEMOP_LH, MEMOP_LHU, MEMOP_SH: size = SZ_H;
      default:                       size = SZ_W;
    endcase
  end

  assign off = ex_i.alu[1:0];

  // halfword on odd byte, word off a word boundary
  assign misalign = is_mem & (((size == SZ_H) & off[0]) | ((size == SZ_W) & (off != 2'b00)));

  assign trap.load_misalign  = is_load & misalign;
  assign trap.store_misalign = is_store & misalign;

  assign is_clint = (ex_i.alu == `MTIME_LO) | (ex_i.alu == `MTIME_HI) |
                    (ex_i.alu == `MTIMECMP_LO) | (ex_i.alu == `MTIMECMP_HI);

  assign acc_ok    = ex_valid_i & is_mem & ~misalign;  // trapped accesses issue nothing
  assign ram_acc   = acc_ok & ~is_clint;
  assign clint_acc = acc_ok & is_clint;

  assign base_mask = (size == SZ_W) ? 4'b1111 :
                     (size == SZ_H) ? 4'b0011 : 4'b0001;

  // trim rs2 to the access size, then move it to its lane
  lsu_ext u_st_ext (
    .data_i   (ex_i.rs2),
    .offset_i (2'b00),
    .size_i   (size),
    .signed_i (1'b0),
    .data_o   (st_trim)
  );

  assign st_wdata = st_trim << {off, 3'b000};

  assign ld_raw = clint_acc ? clint.rdata : dmem.rdata;

  lsu_ext u_ld_ext (
    .data_i   (ld_raw),
    .offset_i (off),
    .size_i   (size),
    .signed_i (ld_signed),
    .data_o   (ld_data)
  );

  // ram side, req held low until the old ack has fallen
  assign dmem.req   = ram_acc & ~(wait_ack_q & dmem.ack);
  assign dmem.we    = is_store;
  assign dmem.addr  = ex_i.alu;
  assign dmem.mask  = base_mask << off;
  assign dmem.size  = size;
  assign dmem.wdata = st_wdata;

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      wait_ack_q <= 1'b0;
    end else if (dmem.req && dmem.ack) begin
      wait_ack_q <= 1'b1;  // result taken this edge
    end else if (!dmem.ack) begin
      wait_ack_q <= 1'b0;
    end
  end

  // waiting for ack, or the old ack still up in front of a new ram op
  assign stall_o = ram_acc & (~dmem.ack | wait_ack_q);

  // clint write must land exactly once
  assign clint.sel   = clint_acc & ~stall_o;
  assign clint.we    = is_store;
  assign clint.addr  = ex_i.alu;
  assign clint.wdata = st_wdata;

  always_comb begin
    wb_o.pc   = ex_i.pc;
    wb_o.rd   = ex_i.rd;
    wb_o.trap = trap;
    if (is_load && !misalign) begin
      wb_o.data = ld_data;
    end else if (ex_i.op == MEMOP_NONE) begin
      wb_o.data = ex_i.alu;  // plain alu result passes on
    end else begin
      wb_o.data = '0;  // stores and traps
    end
  end

endmodule

`default_nettype wire

//--- src/clint.sv
`include "core_params.svh"
`timescale 1ns/1ps
`default_nettype none

module clint (
  input  logic   clk,
  input  logic   rst_n_i,
  clint_if.clint bus,
  output logic   timer_irq_o
);
  import rv_isa_pkg::*;

  logic [63:0] mtime_q;
  logic [63:0] mtimecmp_q;
  logic [63:0] mtime_d;
  logic [63:0] mtimecmp_d;
  logic        wr;
  logic        irq_q;

  assign wr = bus.sel & bus.we;

  // a write to an mtime half replaces the increment
  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    if (wr) begin
      case (bus.addr)
        `MTIME_LO:    mtime_d = {mtime_q[63:32], bus.wdata};
        `MTIME_HI:    mtime_d = {bus.wdata, mtime_q[31:0]};
        `MTIMECMP_LO: mtimecmp_d = {mtimecmp_q[63:32], bus.wdata};
        `MTIMECMP_HI: mtimecmp_d = {bus.wdata, mtimecmp_q[31:0]};
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;  // no interrupt out of reset
      irq_q      <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      irq_q      <= (mtime_q >= mtimecmp_q);
    end
  end

  always_comb begin
    case (bus.addr)
      `MTIME_LO:    bus.rdata = mtime_q[31:0];
      `MTIME_HI:    bus.rdata = mtime_q[63:32];
      `MTIMECMP_LO: bus.rdata = mtimecmp_q[31:0];
      `MTIMECMP_HI: bus.rdata = mtimecmp_q[63:32];
      default:      bus.rdata = '0;
    endcase
  end

  assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

//--- src/data_ram.sv
`include "core_params.svh"
`timescale 1ns/1ps
`default_nettype none

module data_ram (
  input  logic clk,
  input  logic rst_n_i,
  dmem_if.ram  bus
);
  import rv_isa_pkg::*;

  localparam int AW = $clog2(`DMEM_WORDS);
  localparam int CW = $clog2(`DMEM_LATENCY + 1);

  word_t         mem [`DMEM_WORDS];
  logic [AW-1:0] idx;
  logic [CW-1:0] cnt_q;
  logic          ack_q;
  logic          fire;  // ack rises at this edge
  logic [3:0]    span;
  logic [3:0]    be;

  assign idx  = bus.addr[AW+1:2];
  assign fire = bus.req & ~ack_q & (cnt_q == CW'(`DMEM_LATENCY - 1));

  // only bytes both inside the access size and enabled by the mask
  assign span = (bus.size == SZ_W) ? 4'b1111 :
                (bus.size == SZ_H) ? 4'b0011 : 4'b0001;
  assign be   = bus.mask & (span << bus.addr[1:0]);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
      ack_q <= 1'b0;
    end else if (!bus.req) begin
      cnt_q <= '0;  // req dropped, release ack
      ack_q <= 1'b0;
    end else if (fire) begin
      ack_q <= 1'b1;
    end else if (!ack_q) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (fire && bus.we) begin
      for (int b = 0; b < 4; b++) begin
        if (be[b]) mem[idx][8*b +: 8] <= bus.wdata[8*b +: 8];
      end
    end
  end

  assign bus.ack   = ack_q;
  assign bus.rdata = mem[idx];  // whole word, stage picks the lane

endmodule

`default_nettype wire

//--- src/mem_subsys_top.sv
`include "core_params.svh"
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               in_valid_i,
  input  rv_isa_pkg::word_t  in_pc_i,
  input  logic [`REG_AW-1:0] in_rd_i,
  input  rv_isa_pkg::memop_e in_op_i,
  input  rv_isa_pkg::word_t  in_alu_i,
  input  rv_isa_pkg::word_t  in_rs2_i,
  output logic               stall_o,
  output logic               wb_valid_o,
  output rv_isa_pkg::word_t  wb_pc_o,
  output logic [`REG_AW-1:0] wb_rd_o,
  output rv_isa_pkg::word_t  wb_data_o,
  output rv_isa_pkg::trap_t  wb_trap_o,
  output logic               timer_irq_o
);
  import pipe_pkg::*;

  ex_mem_t ex_d;
  ex_mem_t ex_q;
  logic    ex_valid;
  mem_wb_t wb_d;
  mem_wb_t wb_q;
  logic    stall;

  dmem_if  u_dmem_if ();
  clint_if u_clint_if ();

  assign ex_d = '{pc: in_pc_i, rd: in_rd_i, op: in_op_i, alu: in_alu_i, rs2: in_rs2_i};

  // holds under stall, so an input is taken only when stall is low
  pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .hold_i  (stall),
    .flush_i (1'b0),
    .valid_i (in_valid_i),
    .data_i  (ex_d),
    .valid_o (ex_valid),
    .data_o  (ex_q)
  );

  mem_stage u_mem (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .ex_i       (ex_q),
    .ex_valid_i (ex_valid),
    .dmem       (u_dmem_if.stage),
    .clint      (u_clint_if.stage),
    .stall_o    (stall),
    .wb_o       (wb_d)
  );

  // bubble into wb while the stage is stalled
  pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .hold_i  (1'b0),
    .flush_i (stall),
    .valid_i (ex_valid),
    .data_i  (wb_d),
    .valid_o (wb_valid_o),
    .data_o  (wb_q)
  );

  data_ram u_ram (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .bus     (u_dmem_if.ram)
  );

  clint u_clint (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .bus         (u_clint_if.clint),
    .timer_irq_o (timer_irq_o)
  );

  assign stall_o   = stall;
  assign wb_pc_o   = wb_q.pc;
  assign wb_rd_o   = wb_q.rd;
  assign wb_data_o = wb_q.data;
  assign wb_trap_o = wb_q.trap;

endmodule

`default_nettype wire

//--- verification/mem_subsys_sva.sv
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_sva (
  input logic              clk,
  input logic              rst_n_i,
  input logic              req_i,
  input logic              we_i,
  input rv_isa_pkg::word_t addr_i,
  input logic [3:0]        mask_i,
  input rv_isa_pkg::word_t wdata_i,
  input logic              ack_i,
  input logic              stall_i
);

  int fail_cnt = 0;  // count of failed assertions

  // request and its fields frozen until the ram answers
  property req_stable_p;
    @(posedge clk) disable iff (!rst_n_i)
      (req_i && !ack_i) |=> (req_i && $stable(we_i) && $stable(addr_i) &&
                             $stable(mask_i) && $stable(wdata_i));
  endproperty

  // no new request until the old ack is gone
  property no_req_on_ack_p;
    @(posedge clk) disable iff (!rst_n_i)
      $rose(req_i) |-> !ack_i;
  endproperty

  // stall without a request lasts only the cycle the old ack needs to drop
  property stall_idle_p;
    @(posedge clk) disable iff (!rst_n_i)
      (stall_i && !req_i) |=> req_i;
  endproperty

  a_req_stable: assert property (req_stable_p) else begin
    $error("dmem request dropped or changed before ack");
    fail_cnt++;
  end

  a_no_req_on_ack: assert property (no_req_on_ack_p) else begin
    $error("dmem request raised while ack still high");
    fail_cnt++;
  end

  a_stall_idle: assert property (stall_idle_p) else begin
    $error("dmem request not raised after the old ack dropped");
    fail_cnt++;
  end

endmodule

bind mem_stage mem_subsys_sva u_sva (
  .clk     (clk),
  .rst_n_i (rst_n_i),
  .req_i   (dmem.req),
  .we_i    (dmem.we),
  .addr_i  (dmem.addr),
  .mask_i  (dmem.mask),
  .wdata_i (dmem.wdata),
  .ack_i   (dmem.ack),
  .stall_i (stall_o)
);

`default_nettype wire

//--- verification/mem_subsys_tb.sv
`include "core_params.svh"
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_tb;
  import rv_isa_pkg::*;

  localparam int N_FILL     = 64;  // words of ram under test
  localparam int N_MIX      = 300;
  localparam int N_MIS      = 16;
  localparam int N_TMR      = 10;
  localparam int N_OPS      = N_FILL + N_MIX + 3 * N_MIS + N_TMR;
  localparam int TIMEOUT_NS = N_OPS * (`DMEM_LATENCY + 4) * 8 + 2000;
  localparam int DRIVE_DLY  = 1;

  localparam logic [2:0] T_FILL = 3'd0;
  localparam logic [2:0] T_LDST = 3'd1;
  localparam logic [2:0] T_MIS  = 3'd2;
  localparam logic [2:0] T_ALU  = 3'd3;
  localparam logic [2:0] T_TMR  = 3'd4;

  typedef struct packed {
    word_t              pc;
    logic [`REG_AW-1:0] rd;
    word_t              data;
    trap_t              trap;
    logic [2:0]         tid;
  } exp_t;

  logic               clk;
  logic               rst_n_i;
  logic               in_valid_i;
  word_t              in_pc_i;
  logic [`REG_AW-1:0] in_rd_i;
  memop_e             in_op_i;
  word_t              in_alu_i;
  word_t              in_rs2_i;
  logic               stall_o;
  logic               wb_valid_o;
  word_t              wb_pc_o;
  logic [`REG_AW-1:0] wb_rd_o;
  word_t              wb_data_o;
  trap_t              wb_trap_o;
  logic               timer_irq_o;

  int         seed = 5;
  logic [7:0] mem_model [256];  // bytes of the ram region in use
  word_t      cmp_lo = '1;
  word_t      cmp_hi = '1;
  word_t      pc_cnt = 32'h0000_1000;
  exp_t       exp_q [$];
  int         accepted = 0;
  int         results = 0;
  int         value_errs = 0;
  int         other_errs = 0;

  mem_subsys_top u_dut (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (in_valid_i),
    .in_pc_i     (in_pc_i),
    .in_rd_i     (in_rd_i),
    .in_op_i     (in_op_i),
    .in_alu_i    (in_alu_i),
    .in_rs2_i    (in_rs2_i),
    .stall_o     (stall_o),
    .wb_valid_o  (wb_valid_o),
    .wb_pc_o     (wb_pc_o),
    .wb_rd_o     (wb_rd_o),
    .wb_data_o   (wb_data_o),
    .wb_trap_o   (wb_trap_o),
    .timer_irq_o (timer_irq_o)
  );

  always #4 clk = ~clk;

  function automatic word_t rnd();
    return $random(seed);
  endfunction

  function automatic word_t fill_word(input word_t a);
    return (a * 32'h9E37_79B1) ^ 32'hC3A5_5A3C;
  endfunction

  function automatic string test_name(input logic [2:0] t);
    case (t)
      T_FILL:  return "fill";
      T_LDST:  return "ld_st";
      T_MIS:   return "misalign";
      T_ALU:   return "alu_pass";
      default: return "timer";
    endcase
  endfunction

  function automatic memop_e pick_load(input logic [2:0] r);
    case (r)
      3'd0:    return MEMOP_LB;
      3'd1:    return MEMOP_LBU;
      3'd2:    return MEMOP_LH;
      3'd3:    return MEMOP_LHU;
      default: return MEMOP_LW;
    endcase
  endfunction

  function automatic memop_e pick_store(input logic [1:0] r);
    case (r)
      2'd0:    return MEMOP_SB;
      2'd1:    return MEMOP_SH;
      default: return MEMOP_SW;
    endcase
  endfunction

  function automatic word_t align(input memop_e op, input word_t a);
    case (op)
      MEMOP_LH, MEMOP_LHU, MEMOP_SH: return a & ~32'd1;
      MEMOP_LW, MEMOP_SW:            return a & ~32'd3;
      default:                       return a;
    endcase
  endfunction

  // little-endian load with sign or zero fill
  function automatic word_t load_model(input memop_e op, input logic [7:0] a);
    logic [7:0] b0;
    logic [7:0] b1;
    logic [7:0] b2;
    logic [7:0] b3;
    b0 = mem_model[a];
    b1 = mem_model[a + 8'd1];
    b2 = mem_model[a + 8'd2];
    b3 = mem_model[a + 8'd3];
    case (op)
      MEMOP_LB:  return {{24{b0[7]}}, b0};
      MEMOP_LBU: return {24'b0, b0};
      MEMOP_LH:  return {{16{b1[7]}}, b1, b0};
      MEMOP_LHU: return {16'b0, b1, b0};
      default:   return {b3, b2, b1, b0};
    endcase
  endfunction

  function automatic void store_model(input memop_e op, input logic [7:0] a, input word_t d);
    mem_model[a] = d[7:0];
    if (op != MEMOP_SB) mem_model[a + 8'd1] = d[15:8];
    if (op == MEMOP_SW) begin
      mem_model[a + 8'd2] = d[23:16];
      mem_model[a + 8'd3] = d[31:24];
    end
  endfunction

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #(DRIVE_DLY);
    end
  endtask

  // drive one instruction, hold it until taken, queue its expected result
  task automatic issue(input memop_e op, input word_t alu, input word_t rs2,
                       input logic [2:0] tid);
    exp_t               e;
    word_t              r;
    logic               ld;
    logic               st;
    logic               mis;
    logic [`REG_AW-1:0] rd;
    r   = rnd();
    rd  = r[4:0];
    ld  = op inside {MEMOP_LB, MEMOP_LBU, MEMOP_LH, MEMOP_LHU, MEMOP_LW};
    st  = op inside {MEMOP_SB, MEMOP_SH, MEMOP_SW};
    mis = ((op inside {MEMOP_LH, MEMOP_LHU, MEMOP_SH}) && alu[0]) ||
          ((op inside {MEMOP_LW, MEMOP_SW}) && (alu[1:0] != 2'b00));
    e.pc   = pc_cnt;
    e.rd   = rd;
    e.tid  = tid;
    e.data = '0;
    e.trap.load_misalign  = ld & mis;
    e.trap.store_misalign = st & mis;
    if (op == MEMOP_NONE) begin
      e.data = alu;
    end else if (!mis && alu == `MTIMECMP_LO) begin
      if (st) cmp_lo = rs2;
      else e.data = cmp_lo;
    end else if (!mis && alu == `MTIMECMP_HI) begin
      if (st) cmp_hi = rs2;
      else e.data = cmp_hi;
    end else if (!mis && st) begin
      store_model(op, alu[7:0], rs2);
    end else if (!mis) begin
      e.data = load_model(op, alu[7:0]);
    end
    in_valid_i = 1'b1;
    in_pc_i    = pc_cnt;
    in_rd_i    = rd;
    in_op_i    = op;
    in_alu_i   = alu;
    in_rs2_i   = rs2;
    @(negedge clk);
    while (stall_o) @(negedge clk);  // held, not taken yet
    @(posedge clk);
    #(DRIVE_DLY);
    in_valid_i = 1'b0;
    exp_q.push_back(e);
    accepted++;
    pc_cnt = pc_cnt + 32'd4;
  endtask

  task automatic wait_irq(input logic level, input string what);
    int n;
    n = 0;
    while (timer_irq_o !== level && n < 20) begin
      @(posedge clk);
      #(DRIVE_DLY);
      n++;
    end
    assert (timer_irq_o === level) else begin
      $display("timer interrupt did not %s within 20 cycles", what);
      other_errs++;
    end
  endtask

  // every wb result pops the oldest accepted instruction
  always @(negedge clk) begin : wb_check
    exp_t e;
    if (rst_n_i && wb_valid_o) begin
      results++;
      if (exp_q.size() == 0) begin
        $display("result at pc %h with no accepted instruction left", wb_pc_o);
        other_errs++;
      end else begin
        e = exp_q.pop_front();
        assert (wb_pc_o === e.pc && wb_rd_o === e.rd) else begin
          $display("ERR %s pc/rd expected %h/%0d actual %h/%0d", test_name(e.tid),
                   e.pc, e.rd, wb_pc_o, wb_rd_o);
          value_errs++;
        end
        assert (wb_trap_o === e.trap) else begin
          $display("ERR %s trap expected %b actual %b", test_name(e.tid), e.trap, wb_trap_o);
          value_errs++;
        end
        assert (wb_data_o === e.data) else begin
          $display("ERR %s data expected %h actual %h", test_name(e.tid), e.data, wb_data_o);
          value_errs++;
        end
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("watchdog expired after %0d ns, the pipeline hung", TIMEOUT_NS);
    $display("Test failures found");
    $finish;
  end

  initial begin : main
    word_t  r;
    word_t  a;
    word_t  v;
    memop_e op;
    int     sva_errs;
    clk        = 1'b0;
    rst_n_i    = 1'b0;
    in_valid_i = 1'b0;
    in_pc_i    = '0;
    in_rd_i    = '0;
    in_op_i    = MEMOP_NONE;
    in_alu_i   = '0;
    in_rs2_i   = '0;
    repeat (8) @(posedge clk);
    #(DRIVE_DLY);
    // stall, wb valid and timer interrupt all low out of reset
    assert (stall_o === 1'b0 && wb_valid_o === 1'b0 && timer_irq_o === 1'b0) else begin
      $display("ERR reset stall/valid/irq expected 000 actual %b%b%b",
               stall_o, wb_valid_o, timer_irq_o);
      value_errs++;
    end
    rst_n_i = 1'b1;

    // known contents for the region, every word written once
    for (int w = 0; w < N_FILL; w++) begin
      a = word_t'(w) << 2;
      issue(MEMOP_SW, a, fill_word(a), T_FILL);
    end

    // random loads, stores and alu pass-through with gaps
    for (int i = 0; i < N_MIX; i++) begin
      r = rnd();
      v = rnd();
      if (r[10:8] < 3'd2) begin
        op = pick_store(r[1:0]);
        issue(op, align(op, {24'b0, r[23:16]}), v, T_LDST);
      end else if (r[10:8] < 3'd5) begin
        op = pick_load(r[4:2]);
        issue(op, align(op, {24'b0, r[23:16]}), v, T_LDST);
      end else begin
        issue(MEMOP_NONE, v, rnd(), T_ALU);
      end
      if (r[31:30] == 2'b00) idle(1);
    end

    // misaligned store, misaligned load, then the word behind them
    for (int i = 0; i < N_MIS; i++) begin
      r = rnd();
      a = {24'b0, r[7:2], 2'b00};
      if (r[10]) begin
        issue(MEMOP_SH, a | {30'b0, r[9], 1'b1}, rnd(), T_MIS);
      end else begin
        issue(MEMOP_SW, a | {30'b0, (r[9:8] == 2'b00) ? 2'b10 : r[9:8]}, rnd(), T_MIS);
      end
      issue(r[11] ? MEMOP_LHU : MEMOP_LW, a | {30'b0, r[12], 1'b1}, '0, T_MIS);
      issue(MEMOP_LW, a, '0, T_MIS);
    end

    // mtimecmp read back, then the interrupt rises and falls
    issue(MEMOP_SW, `MTIMECMP_LO, rnd(), T_TMR);
    issue(MEMOP_LW, `MTIMECMP_LO, '0, T_TMR);
    issue(MEMOP_SW, `MTIMECMP_HI, 32'hFFFF_FFFF, T_TMR);
    issue(MEMOP_LW, `MTIMECMP_HI, '0, T_TMR);
    assert (timer_irq_o === 1'b0) else begin
      $display("ERR timer irq expected 0 actual %b", timer_irq_o);
      value_errs++;
    end
    issue(MEMOP_SW, `MTIMECMP_HI, '0, T_TMR);
    issue(MEMOP_SW, `MTIMECMP_LO, '0, T_TMR);
    wait_irq(1'b1, "rise");
    issue(MEMOP_SW, `MTIMECMP_HI, 32'hFFFF_FFFF, T_TMR);
    wait_irq(1'b0, "fall");
    issue(MEMOP_LW, `MTIMECMP_HI, '0, T_TMR);

    while (exp_q.size() != 0) @(negedge clk);
    repeat (6) @(negedge clk);  // catch any duplicate result
    assert (results == accepted) else begin
      $display("got %0d results for %0d accepted instructions", results, accepted);
      other_errs++;
    end

    sva_errs = u_dut.u_mem.u_sva.fail_cnt;
    $display("errors: %0d value, %0d other, %0d assertion; %0d results, %0d accepted",
             value_errs, other_errs, sva_errs, results, accepted);
    if (value_errs + other_errs + sva_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
+incdir+src
src/rv_isa_pkg.sv
src/pipe_pkg.sv
src/mem_bus_if.sv
src/lsu_ext.sv
src/pipe_reg.sv
src/mem_stage.sv
src/clint.sv
src/data_ram.sv
src/mem_subsys_top.sv
verification/mem_subsys_sva.sv
verification/mem_subsys_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module mem_subsys_tb \
  -f tb.f \
  -Mdir obj_dir -o sim

# keep running past assertion errors so the summary is printed
./obj_dir/sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation FAILED"
  exit 1
fi
if ! grep -q "All tests passed!" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
echo "simulation PASSED"
